//--- decodeStage.f
src/isaPkg.sv
src/pipePkg.sv
src/fetchUnpack.sv
src/mainDecode.sv
src/signalDecode.sv
src/issueBundle.sv
src/decodeStage.sv
sim/clockGen.sv
sim/decodeStageTb.sv

//--- sim/clockGen.sv
`timescale 1ns/1ns

module clockGen (
	output logic clk,
	output logic rstN
);

	// 40 ns period
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// reset held over ten rising edges, released just after one
	initial begin
		rstN = 1'b0;
		repeat (10) @(posedge clk);
		#2;
		rstN = 1'b1;
	end

endmodule

//--- sim/decodeStageTb.sv
`timescale 1ns/1ns

module decodeStageTb import isaPkg::*, pipePkg::*;;

	logic clk;
	logic rstN;
	logic fetchValid;
	fetch_bundle_t fetchBundle;
	logic issueValid;
	issue_bundle_t issueBundle;
	word_t rngState = 32'h567c_9ac1;

	clockGen clockGen_i (
		.clk(clk),
		.rstN(rstN)
	);

	decodeStage decodeStage_i (
		.clk(clk),
		.rstN(rstN),
		.fetchValid(fetchValid),
		.fetchBundle(fetchBundle),
		.issueValid(issueValid),
		.issueBundle(issueBundle)
	);

	// xorshift32 stimulus source
	function automatic word_t nextRandom();
		rngState ^= rngState << 13;
		rngState ^= rngState >> 17;
		rngState ^= rngState << 5;
		return rngState;
	endfunction

	function automatic creg_addr_t randReg();
		return creg_addr_t'(nextRandom());
	endfunction

	// instruction encoders per format
	function automatic word_t rWord(input func_t fn, input creg_addr_t rs, input creg_addr_t rt,
		input creg_addr_t rd, input shamt_t sa);
		return {opRtype, rs, rt, rd, sa, fn};
	endfunction

	function automatic word_t iWord(input op_t op, input creg_addr_t rs, input creg_addr_t rt,
		input halfword_t imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t jWord(input op_t op, input word_t target);
		return {op, target[25:0]};
	endfunction

	// R-type word with every field random
	function automatic word_t randR(input func_t fn);
		return rWord(fn, randReg(), randReg(), randReg(), shamt_t'(nextRandom()));
	endfunction

	function automatic fetch_bundle_t makeBundle(input word_t pc, input word_t w0,
		input word_t w1, input logic exc);
		fetch_bundle_t b;
		b.pc = pc;
		b.instr[0] = w0;
		b.instr[1] = w1;
		b.exceptionInstr = exc;
		return b;
	endfunction

	// reference decoder for one lane
	function automatic decode_data_t refDecode(input word_t instr, input word_t pcPlus4,
		input logic exc);
		decode_data_t d;
		creg_addr_t rs;
		creg_addr_t rt;
		creg_addr_t rd;
		halfword_t imm;
		rs = instr[25:21];
		rt = instr[20:16];
		rd = instr[15:11];
		imm = instr[15:0];
		d = '0;
		d.op = RESERVED;
		case (instr[31:26])
			opRtype: begin
				case (instr[5:0])
					fnAddu: d.op = ADDU;
					fnSubu: d.op = SUBU;
					fnAnd: d.op = AND;
					fnOr: d.op = OR;
					fnSlt: d.op = SLT;
					fnSll: d.op = SLL;
					fnSrl: d.op = SRL;
					fnJr: d.op = JR;
				endcase
			end
			opAddiu: d.op = ADDIU;
			opAndi: d.op = ANDI;
			opOri: d.op = ORI;
			opLui: d.op = LUI;
			opLw: d.op = LW;
			opSw: d.op = SW;
			opBeq: d.op = BEQ;
			opBne: d.op = BNE;
			opJ: d.op = J;
			opJal: d.op = JAL;
		endcase
		// regWrite memRead memWrite aluSrcImm zeroExt branch jump link
		case (d.op)
			ADDU, SUBU, AND, OR, SLT, SLL, SRL: d.ctl = 8'b1000_0000;
			ADDIU, LUI: d.ctl = 8'b1001_0000;
			ANDI, ORI: d.ctl = 8'b1001_1000;
			LW: d.ctl = 8'b1101_0000;
			SW: d.ctl = 8'b0011_0000;
			BEQ, BNE: d.ctl = 8'b0000_0100;
			JR, J: d.ctl = 8'b0000_0010;
			JAL: d.ctl = 8'b1000_0011;
			default: d.ctl = '0;
		endcase
		// registers actually read and written
		// unused ones stay zero, R-type keeps rd as destination
		case (d.op)
			ADDU, SUBU, AND, OR, SLT: {d.srcRegA, d.srcRegB, d.destReg} = {rs, rt, rd};
			SLL, SRL: {d.srcRegA, d.destReg} = {rt, rd};
			JR: {d.srcRegA, d.destReg} = {rs, rd};
			ADDIU, ANDI, ORI, LW: {d.srcRegA, d.destReg} = {rs, rt};
			LUI: d.destReg = rt;
			SW, BEQ, BNE: {d.srcRegA, d.srcRegB} = {rs, rt};
			JAL: d.destReg = 5'd31;
			default: ;
		endcase
		d.extendedImm = (d.op == LUI) ? {imm, 16'h0000} :
			(d.op == ANDI || d.op == ORI) ? {16'h0000, imm} : {{16{imm[15]}}, imm};
		d.pcBranch = pcPlus4 + (d.extendedImm << 2);
		d.pcJump = {pcPlus4[31:28], instr[25:0], 2'b00};
		d.shamt = instr[10:6];
		d.cp0Addr = rd;
		d.pcPlus4 = pcPlus4;
		d.exceptionRi = (d.op == RESERVED);
		d.exceptionInstr = exc;
		return d;
	endfunction

	// both lanes plus delay slot and dependency marks
	function automatic issue_bundle_t expectBundle(input fetch_bundle_t b);
		issue_bundle_t e;
		for (int i = 0; i < laneCount; i++) begin
			e.lane[i] = refDecode(b.instr[i], b.pc + 4 * (i + 1), b.exceptionInstr);
		end
		e.lane[1].inDelaySlot = e.lane[0].ctl.branch | e.lane[0].ctl.jump;
		e.laneDep = e.lane[0].ctl.regWrite && e.lane[0].destReg != 5'd0 &&
			(e.lane[0].destReg == e.lane[1].srcRegA || e.lane[0].destReg == e.lane[1].srcRegB);
		return e;
	endfunction

	task automatic abortRun(input string msg);
		$display("%s", msg);
		$display("Finished with errors");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic compareDecode(input decode_data_t got, input decode_data_t exp,
		input string what);
		if (got !== exp) begin
			abortRun($sformatf("ERROR at %0t ns: %s got %h expected %h", $time, what, got, exp));
		end
	endtask

	task automatic compareFlag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			abortRun($sformatf("ERROR at %0t ns: %s got %b expected %b", $time, what, got, exp));
		end
	endtask

	task automatic compareWord(input word_t got, input word_t exp, input string what);
		if (got !== exp) begin
			abortRun($sformatf("ERROR at %0t ns: %s got %h expected %h", $time, what, got, exp));
		end
	endtask

	task automatic waitReset();
		int cycles;
		cycles = 0;
		while (rstN !== 1'b1) begin
			@(posedge clk);
			#1;
			cycles++;
			if (cycles > 30) begin
				abortRun("reset was never released");
			end
		end
	endtask

	// counts edges until issueValid
	// sampled 1 ns after each edge
	task automatic waitIssue(output int cycles);
		cycles = 0;
		do begin
			@(posedge clk);
			#1;
			cycles++;
			if (cycles > 20) begin
				abortRun("issueValid did not rise within 20 cycles of the strobe");
			end
		end while (issueValid !== 1'b1);
	endtask

	// one strobe then a check of the issued bundle and its latency
	task automatic runBundle(input fetch_bundle_t b);
		issue_bundle_t exp;
		int cycles;
		exp = expectBundle(b);
		@(posedge clk);
		#2;
		fetchValid = 1'b1;
		fetchBundle = b;
		@(posedge clk);
		#2;
		fetchValid = 1'b0;
		waitIssue(cycles);
		// the edge that took the strobe is the first latency cycle
		compareWord(word_t'(cycles + 1), 32'd2, "issue latency");
		compareDecode(issueBundle.lane[0], exp.lane[0], "lane 0");
		compareDecode(issueBundle.lane[1], exp.lane[1], "lane 1");
		compareFlag(issueBundle.laneDep, exp.laneDep, "laneDep");
	endtask

	task automatic rtypeWords();
		func_t fns[8] = '{fnAddu, fnSubu, fnAnd, fnOr, fnSlt, fnSll, fnSrl, fnJr};
		for (int k = 0; k < 8; k++) begin
			runBundle(makeBundle(nextRandom() & ~32'h3, randR(fns[k]), randR(fns[7 - k]), 1'b0));
		end
	endtask

	task automatic itypeWords();
		op_t ops[6] = '{opAddiu, opAndi, opOri, opLui, opLw, opSw};
		halfword_t imm;
		for (int k = 0; k < 12; k++) begin
			// second pass over the opcodes uses negative immediates
			imm = (k < 6) ? (halfword_t'(nextRandom()) & 16'h7fff) :
				(halfword_t'(nextRandom()) | 16'h8000);
			runBundle(makeBundle(32'h0040_0000, iWord(ops[k % 6], randReg(), randReg(), imm),
				randR(fnAddu), 1'b0));
			if (ops[k % 6] == opSw) begin
				compareFlag(issueBundle.lane[0].ctl.regWrite, 1'b0, "SW regWrite");
			end
		end
	endtask

	task automatic branchTargets();
		word_t pc;
		word_t w0;
		for (int k = 0; k < 8; k++) begin
			pc = nextRandom() & ~32'h3;
			case (k % 4)
				0: w0 = iWord(opBeq, randReg(), randReg(), halfword_t'(nextRandom()));
				1: w0 = iWord(opBne, randReg(), randReg(), halfword_t'(nextRandom()));
				2: w0 = jWord(opJ, nextRandom());
				default: w0 = jWord(opJal, nextRandom());
			endcase
			runBundle(makeBundle(pc, w0, randR(fnOr), 1'b0));
			compareWord(issueBundle.lane[1].pcPlus4, pc + 32'd8, "lane 1 pcPlus4");
			if (k % 4 == 3) begin
				compareWord(word_t'(issueBundle.lane[0].destReg), 32'd31, "JAL destReg");
			end
		end
	endtask

	task automatic reservedWords();
		// opcodes 3f and 08 plus R-type functs 01 and 20
		word_t bad[4] = '{32'hfc00_1234, 32'h2000_0001, 32'h0000_0001, 32'h0123_4820};
		for (int k = 0; k < 4; k++) begin
			runBundle(makeBundle(32'h0000_8000, bad[k] ^ (nextRandom() & 32'h03ff_ffc0),
				bad[3 - k], 1'b1));
			for (int i = 0; i < laneCount; i++) begin
				compareFlag(issueBundle.lane[i].exceptionRi, 1'b1, "exceptionRi");
				compareFlag(issueBundle.lane[i].ctl == '0, 1'b1, "reserved ctl is zero");
				compareFlag(issueBundle.lane[i].exceptionInstr, 1'b1, "fetch exception flag");
			end
		end
	endtask

	task automatic bundleMarks();
		runBundle(makeBundle(32'h0000_1000, iWord(opBeq, 5'd1, 5'd2, 16'h0010),
			rWord(fnAddu, 5'd3, 5'd4, 5'd5, 5'd0), 1'b0));
		compareFlag(issueBundle.lane[1].inDelaySlot, 1'b1, "delay slot after BEQ");
		// rd 7 feeds lane 1 rs
		runBundle(makeBundle(32'h0000_1000, rWord(fnAddu, 5'd1, 5'd2, 5'd7, 5'd0),
			rWord(fnSubu, 5'd7, 5'd3, 5'd4, 5'd0), 1'b0));
		compareFlag(issueBundle.laneDep, 1'b1, "RAW on rs");
		// load result used as store data
		runBundle(makeBundle(32'h0000_1000, iWord(opLw, 5'd1, 5'd8, 16'h0004),
			iWord(opSw, 5'd2, 5'd8, 16'h0000), 1'b0));
		compareFlag(issueBundle.laneDep, 1'b1, "RAW on SW data");
		// r0 never carries a dependency
		runBundle(makeBundle(32'h0000_1000, rWord(fnOr, 5'd1, 5'd2, 5'd0, 5'd0),
			rWord(fnAnd, 5'd0, 5'd0, 5'd6, 5'd0), 1'b0));
		compareFlag(issueBundle.laneDep, 1'b0, "write to r0");
		// SLL ignores rs
		runBundle(makeBundle(32'h0000_1000, iWord(opAddiu, 5'd1, 5'd9, 16'h0005),
			rWord(fnSll, 5'd9, 5'd3, 5'd4, 5'd2), 1'b0));
		compareFlag(issueBundle.laneDep, 1'b0, "SLL rs unused");
		// ORI writes rt and does not read it
		runBundle(makeBundle(32'h0000_1000, iWord(opLui, 5'd0, 5'd5, 16'h1234),
			iWord(opOri, 5'd2, 5'd5, 16'h00ff), 1'b0));
		compareFlag(issueBundle.laneDep, 1'b0, "ORI rt unused");
	endtask

	task automatic backToBackStrobes();
		fetch_bundle_t b[3];
		issue_bundle_t exp[3];
		int idx;
		for (int k = 0; k < 3; k++) begin
			b[k] = makeBundle(nextRandom() & ~32'h3, randR(fnSlt),
				iWord(opLw, randReg(), randReg(), halfword_t'(nextRandom())), 1'b0);
			exp[k] = expectBundle(b[k]);
		end
		// strobes driven in cycles 0..2
		// results seen in cycles 2..4 and held after that
		for (int c = 0; c < 8; c++) begin
			@(posedge clk);
			#1;
			compareFlag(issueValid, (c >= 2 && c <= 4), "issueValid timing");
			if (c >= 2) begin
				idx = (c > 4) ? 2 : c - 2;
				compareDecode(issueBundle.lane[0], exp[idx].lane[0], "back-to-back lane 0");
				compareDecode(issueBundle.lane[1], exp[idx].lane[1], "back-to-back lane 1");
				compareFlag(issueBundle.laneDep, exp[idx].laneDep, "back-to-back laneDep");
			end
			#1;
			fetchValid = (c < 3);
			if (c < 3) begin
				fetchBundle = b[c];
			end
		end
	endtask

	initial begin
		fetchValid = 1'b0;
		fetchBundle = '0;
		waitReset();
		compareFlag(issueValid, 1'b0, "issueValid after reset");
		compareFlag(issueBundle == '0, 1'b1, "issueBundle zero after reset");
		rtypeWords();
		itypeWords();
		branchTargets();
		reservedWords();
		bundleMarks();
		backToBackStrobes();
		$display("Finished with no errors");
		$finish;
	end

endmodule

//--- src/decodeStage.sv
`timescale 1ns/1ns

module decodeStage import pipePkg::*; (
	input logic clk,
	input logic rstN,
	input logic fetchValid,
	input fetch_bundle_t fetchBundle,
	output logic issueValid,
	output issue_bundle_t issueBundle
);

	logic laneValid;
	fetch_data_t [laneCount-1:0] laneData;
	decode_data_t [laneCount-1:0] laneDecoded;

	// first cycle, bundle register and split
	fetchUnpack fetchUnpack_i (
		.clk(clk),
		.rstN(rstN),
		.fetchValid(fetchValid),
		.fetchBundle(fetchBundle),
		.laneValid(laneValid),
		.laneData(laneData)
	);

	// combinational decode, one per lane
	for (genvar i = 0; i < laneCount; i++) begin : gLane
		signalDecode signalDecode_i (
			.dataF(laneData[i]),
			.dataD(laneDecoded[i])
		);
	end

	// second cycle, bundle marks and issue register
	issueBundle issueBundle_i (
		.clk(clk),
		.rstN(rstN),
		.laneValid(laneValid),
		.laneDecoded(laneDecoded),
		.issueValid(issueValid),
		.issueBundle(issueBundle)
	);

endmodule

//--- src/fetchUnpack.sv
`timescale 1ns/1ns

module fetchUnpack import isaPkg::*, pipePkg::*; (
	input logic clk,
	input logic rstN,
	input logic fetchValid,
	input fetch_bundle_t fetchBundle,
	output logic laneValid,
	output fetch_data_t [laneCount-1:0] laneData
);

	// strobe delayed by one cycle
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			laneValid <= 1'b0;
		end else begin
			laneValid <= fetchValid;
		end
	end

	// split the bundle into per-lane records on each strobe
	// lane i sits at pc + 4*i, so its pcPlus4 is pc + 4*(i+1)
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			laneData <= '0;
		end else if (fetchValid) begin
			for (int i = 0; i < laneCount; i++) begin
				laneData[i].instr <= fetchBundle.instr[i];
				laneData[i].pcPlus4 <= fetchBundle.pc + word_t'(4 * (i + 1));
				// fetch fault covers the whole bundle
				laneData[i].exceptionInstr <= fetchBundle.exceptionInstr;
			end
		end
	end

endmodule

//--- src/isaPkg.sv
package isaPkg;

	// basic word widths
	typedef logic [31:0] word_t;
	typedef logic [15:0] halfword_t;

	// instruction fields
	typedef logic [5:0] op_t;
	typedef logic [5:0] func_t;
	typedef logic [4:0] creg_addr_t;
	typedef logic [4:0] shamt_t;

	// primary opcodes
	localparam op_t opRtype = 6'h00;
	localparam op_t opJ     = 6'h02;
	localparam op_t opJal   = 6'h03;
	localparam op_t opBeq   = 6'h04;
	localparam op_t opBne   = 6'h05;
	localparam op_t opAddiu = 6'h09;
	localparam op_t opAndi  = 6'h0c;
	localparam op_t opOri   = 6'h0d;
	localparam op_t opLui   = 6'h0f;
	localparam op_t opLw    = 6'h23;
	localparam op_t opSw    = 6'h2b;

	// funct codes, R-type only
	localparam func_t fnSll  = 6'h00;
	localparam func_t fnSrl  = 6'h02;
	localparam func_t fnJr   = 6'h08;
	localparam func_t fnAddu = 6'h21;
	localparam func_t fnSubu = 6'h23;
	localparam func_t fnAnd  = 6'h24;
	localparam func_t fnOr   = 6'h25;
	localparam func_t fnSlt  = 6'h2a;

	// link register for JAL
	localparam creg_addr_t regRa = 5'd31;

	// decoded operation
	// anything outside the subset lands on RESERVED
	typedef enum logic [4:0] {
		RESERVED,
		ADDU,
		SUBU,
		AND,
		OR,
		SLT,
		SLL,
		SRL,
		JR,
		ADDIU,
		ANDI,
		ORI,
		LUI,
		LW,
		SW,
		BEQ,
		BNE,
		J,
		JAL
	} decoded_op_t;

endpackage

//--- src/issueBundle.sv
`timescale 1ns/1ns

module issueBundle import pipePkg::*; (
	input logic clk,
	input logic rstN,
	input logic laneValid,
	input decode_data_t [laneCount-1:0] laneDecoded,
	output logic issueValid,
	output issue_bundle_t issueBundle
);

	logic slotMark;
	logic depMark;

	// lane 1 follows a control transfer in lane 0
	assign slotMark = laneDecoded[0].ctl.branch | laneDecoded[0].ctl.jump;

	// RAW inside the bundle
	// writes to r0 never count, srcRegB is zero when unused
	always_comb begin
		depMark = 1'b0;
		if (laneDecoded[0].ctl.regWrite && laneDecoded[0].destReg != '0) begin
			if (laneDecoded[0].destReg == laneDecoded[1].srcRegA ||
				laneDecoded[0].destReg == laneDecoded[1].srcRegB) begin
				depMark = 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			issueValid <= 1'b0;
		end else begin
			issueValid <= laneValid;
		end
	end

	// hold between strobes
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			issueBundle <= '0;
		end else if (laneValid) begin
			issueBundle.lane <= laneDecoded;
			issueBundle.lane[1].inDelaySlot <= slotMark;
			issueBundle.laneDep <= depMark;
		end
	end

endmodule

//--- src/mainDecode.sv
`timescale 1ns/1ns

module mainDecode import isaPkg::*, pipePkg::*; (
	input word_t instr,
	output decoded_op_t op,
	output ctl_t ctl,
	output creg_addr_t srcRegA,
	output creg_addr_t srcRegB,
	output creg_addr_t destReg,
	output logic exceptionRi
);

	op_t opcode;
	func_t func;
	creg_addr_t rs;
	creg_addr_t rt;
	creg_addr_t rd;

	assign opcode = instr[31:26];
	assign func = instr[5:0];
	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign rd = instr[15:11];

	always_comb begin
		// defaults describe a reserved word
		op = RESERVED;
		ctl = '0;
		srcRegA = rs;
		srcRegB = rt;
		destReg = '0;
		unique case (opcode)
			opRtype: begin
				destReg = rd;
				ctl.regWrite = 1'b1;
				unique case (func)
					fnAddu: op = ADDU;
					fnSubu: op = SUBU;
					fnAnd: op = AND;
					fnOr: op = OR;
					fnSlt: op = SLT;
					fnSll, fnSrl: begin
						op = (func == fnSll) ? SLL : SRL;
						// shifts read rt only
						srcRegA = rt;
						srcRegB = '0;
					end
					fnJr: begin
						op = JR;
						ctl.regWrite = 1'b0;
						ctl.jump = 1'b1;
						srcRegB = '0;
					end
					default: begin
						// unknown funct, undo the R-type guesses
						ctl = '0;
						destReg = '0;
					end
				endcase
			end
			opAddiu, opAndi, opOri, opLui, opLw: begin
				destReg = rt;
				srcRegB = '0;
				ctl.regWrite = 1'b1;
				ctl.aluSrcImm = 1'b1;
				unique case (opcode)
					opAddiu: op = ADDIU;
					opAndi: begin
						op = ANDI;
						ctl.zeroExt = 1'b1;
					end
					opOri: begin
						op = ORI;
						ctl.zeroExt = 1'b1;
					end
					opLui: begin
						op = LUI;
						// no source at all
						srcRegA = '0;
					end
					default: begin
						op = LW;
						ctl.memRead = 1'b1;
					end
				endcase
			end
			opSw: begin
				// base in rs, store data in rt
				op = SW;
				ctl.memWrite = 1'b1;
				ctl.aluSrcImm = 1'b1;
			end
			opBeq, opBne: begin
				op = (opcode == opBeq) ? BEQ : BNE;
				ctl.branch = 1'b1;
			end
			opJ, opJal: begin
				op = (opcode == opJ) ? J : JAL;
				ctl.jump = 1'b1;
				srcRegA = '0;
				srcRegB = '0;
				if (opcode == opJal) begin
					// return address into ra
					ctl.link = 1'b1;
					ctl.regWrite = 1'b1;
					destReg = regRa;
				end
			end
			default: ;
		endcase
		// reserved words read nothing either
		if (op == RESERVED) begin
			srcRegA = '0;
			srcRegB = '0;
		end
	end

	assign exceptionRi = (op == RESERVED);

endmodule

//--- src/pipePkg.sv
package pipePkg;

	import isaPkg::*;

	// lanes per fetch bundle
	localparam int laneCount = 2;

	// control bits produced per lane
	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		// second ALU operand from the immediate
		logic aluSrcImm;
		logic zeroExt;
		logic branch;
		logic jump;
		logic link;
	} ctl_t;

	// one lane leaving the unpacker
	typedef struct packed {
		word_t instr;
		word_t pcPlus4;
		logic exceptionInstr;
	} fetch_data_t;

	// one lane leaving decode
	typedef struct packed {
		decoded_op_t op;
		ctl_t ctl;
		shamt_t shamt;
		word_t extendedImm;
		word_t pcBranch;
		word_t pcJump;
		creg_addr_t srcRegA;
		creg_addr_t srcRegB;
		creg_addr_t destReg;
		creg_addr_t cp0Addr;
		word_t pcPlus4;
		logic exceptionRi;
		logic exceptionInstr;
		logic inDelaySlot;
	} decode_data_t;

	// raw bundle from fetch
	typedef struct packed {
		word_t pc;
		word_t [laneCount-1:0] instr;
		logic exceptionInstr;
	} fetch_bundle_t;

	// registered bundle handed to issue
	typedef struct packed {
		decode_data_t [laneCount-1:0] lane;
		// lane 1 reads what lane 0 writes
		logic laneDep;
	} issue_bundle_t;

endpackage

//--- src/signalDecode.sv
`timescale 1ns/1ns

module signalDecode import isaPkg::*, pipePkg::*; (
	input fetch_data_t dataF,
	output decode_data_t dataD
);

	halfword_t imm;
	word_t extImm;

	assign imm = dataF.instr[15:0];

	// opcode and funct decode
	mainDecode mainDecode_i (
		.instr(dataF.instr),
		.op(dataD.op),
		.ctl(dataD.ctl),
		.srcRegA(dataD.srcRegA),
		.srcRegB(dataD.srcRegB),
		.destReg(dataD.destReg),
		.exceptionRi(dataD.exceptionRi)
	);

	assign dataD.shamt = dataF.instr[10:6];
	// mfc0/mtc0 register number lives in rd
	assign dataD.cp0Addr = dataF.instr[15:11];

	// immediate extension
	always_comb begin
		if (dataD.op == LUI) begin
			extImm = {imm, 16'h0000};
		end else if (dataD.ctl.zeroExt) begin
			extImm = {16'h0000, imm};
		end else begin
			extImm = {{16{imm[15]}}, imm};
		end
	end
	assign dataD.extendedImm = extImm;

	// targets relative to the delay slot address
	assign dataD.pcBranch = dataF.pcPlus4 + {extImm[29:0], 2'b00};
	assign dataD.pcJump = {dataF.pcPlus4[31:28], dataF.instr[25:0], 2'b00};

	assign dataD.pcPlus4 = dataF.pcPlus4;
	assign dataD.exceptionInstr = dataF.exceptionInstr;
	// set later at bundle level
	assign dataD.inDelaySlot = 1'b0;

endmodule
